/* source/rot_pkg.sv */
package rot_pkg;

  // default sizes for the kernel path.
  localparam int DEF_R_DEPTH      = 8;   // weight words held.
  localparam int DEF_R_DATA_WIDTH = 16;  // weight and pixel width.
  localparam int DEF_W_DATA_WIDTH = 64;  // four weights per beat.
  localparam int DEF_ACC_WIDTH    = 40;  // accumulator headroom.

  localparam int OUT_WIDTH = 16;  // clamped output word.

  // sampled with the first pixel of a pass.
  typedef enum logic {
    OP_CLEAR = 1'b0,  // start the sum at zero.
    OP_ACCUM = 1'b1   // keep the previous pass's sum.
  } mac_op_e;

  // MAC pass control.
  typedef enum logic {
    ST_IDLE = 1'b0,  // waiting for the first pixel.
    ST_RUN  = 1'b1   // inside a pass.
  } mac_state_e;

  // mac_stage to result_clamp.
  typedef struct packed {
    logic signed [DEF_ACC_WIDTH-1:0] sum;
    logic                            valid;
  } mac_result_t;

  // top level output word.
  typedef struct packed {
    logic signed [OUT_WIDTH-1:0] data;
    logic                        sat;  // set when clipped.
  } out_word_t;

endpackage

/* source/weight_loader.sv */
module weight_loader #(
  parameter int W_ADDR_WIDTH = 1
)(
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    clken,
  input  logic                    beat_valid,
  input  logic [W_ADDR_WIDTH-1:0] w_addr_max,
  output logic                    w_en,
  output logic [W_ADDR_WIDTH-1:0] w_addr,
  output logic                    loaded
);

  logic last_beat;
  logic [W_ADDR_WIDTH-1:0] w_addr_next;

  // the beat is written at the coming edge.
  assign w_en = beat_valid;

  assign last_beat   = (w_addr == w_addr_max);
  assign w_addr_next = last_beat ? '0 : w_addr + 1'b1;

  // beat counter, wraps after the last beat.
  always_ff @(posedge clk) begin
    if (rst) begin
      w_addr <= '0;
    end else if (clken && beat_valid) begin
      w_addr <= w_addr_next;
    end
  end

  // high after the final beat, low again once a new load starts.
  always_ff @(posedge clk) begin
    if (rst) begin
      loaded <= 1'b0;
    end else if (clken && beat_valid) begin
      loaded <= last_beat;
    end
  end

  a_addr_in_range: assert property (
    @(posedge clk) disable iff (rst)
    w_addr <= w_addr_max
  ) else $error("weight_loader: w_addr %0d past w_addr_max %0d", w_addr, w_addr_max);

endmodule

/* source/cyclic_shift_reg.sv */
module cyclic_shift_reg #(
  parameter  int R_DEPTH         = rot_pkg::DEF_R_DEPTH,
  parameter  int R_DATA_WIDTH    = rot_pkg::DEF_R_DATA_WIDTH,
  parameter  int W_DATA_WIDTH    = rot_pkg::DEF_W_DATA_WIDTH,
  parameter  bit OVERRIDE_W_ADDR = 1'b0,
  localparam int RATIO           = W_DATA_WIDTH / R_DATA_WIDTH,
  localparam int W_DEPTH         = R_DEPTH * R_DATA_WIDTH / W_DATA_WIDTH,
  localparam int W_ADDR_WIDTH    = (W_DEPTH > 1) ? $clog2(W_DEPTH) : 1,
  localparam int R_ADDR_WIDTH    = (R_DEPTH > 1) ? $clog2(R_DEPTH) : 1
)(
  input  logic                                clk,
  input  logic                                clken,
  input  logic                                rst,
  input  logic                                w_en,
  input  logic                                r_en,
  input  logic [RATIO-1:0][R_DATA_WIDTH-1:0]  s_data,
  output logic [R_DATA_WIDTH-1:0]             m_data,
  input  logic [R_ADDR_WIDTH-1:0]             r_addr_max,
  input  logic [W_ADDR_WIDTH-1:0]             w_addr_max,
  input  logic [W_ADDR_WIDTH-1:0]             w_addr_in
);

  logic [R_DEPTH-1:0][R_DATA_WIDTH-1:0] words;
  logic [R_DEPTH-1:0][R_DATA_WIDTH-1:0] rot_data;
  logic [R_DEPTH-1:0]                   w_sel;
  logic [R_DEPTH-1:0]                   rot_sel;
  logic [W_ADDR_WIDTH-1:0]              w_addr;

  // write address, from the loader or counted here.
  generate
    if (OVERRIDE_W_ADDR) begin : g_addr_ext
      assign w_addr = w_addr_in;
    end else begin : g_addr_count
      logic [W_ADDR_WIDTH-1:0] w_addr_cnt;

      always_ff @(posedge clk) begin
        if (rst) begin
          w_addr_cnt <= '0;
        end else if (clken && w_en) begin
          w_addr_cnt <= (w_addr_cnt == w_addr_max) ? '0 : w_addr_cnt + 1'b1;
        end
      end

      assign w_addr = w_addr_cnt;
    end
  endgenerate

  // per-position write select and rotate source.
  generate
    for (genvar r = 0; r < R_DEPTH; r++) begin : g_word
      assign w_sel[r]   = w_en && (w_addr == W_ADDR_WIDTH'(r / RATIO));
      assign rot_sel[r] = (R_ADDR_WIDTH'(r) <= r_addr_max);  // active region only.
      assign rot_data[r] = (R_ADDR_WIDTH'(r) == r_addr_max) ? words[0]
                                                             : words[(r + 1) % R_DEPTH];
    end
  endgenerate

  // word registers. write wins, otherwise rotate on read.
  always_ff @(posedge clk) begin
    if (rst) begin
      words <= '0;
    end else if (clken) begin
      for (int r = 0; r < R_DEPTH; r++) begin
        if (w_sel[r]) begin
          words[r] <= s_data[r % RATIO];
        end else if (r_en && rot_sel[r]) begin
          words[r] <= rot_data[r];
        end
      end
    end
  end

  // head of the rotation feeds the MAC.
  assign m_data = words[0];

  // loader and MAC must never drive the buffer in the same cycle.
  a_no_write_on_read: assert property (
    @(posedge clk) disable iff (rst)
    !(w_en && r_en)
  ) else $error("cyclic_shift_reg: write and read strobes together");

  a_w_addr_in_range: assert property (
    @(posedge clk) disable iff (rst)
    w_en |-> (w_addr <= w_addr_max)
  ) else $error("cyclic_shift_reg: write to address %0d past %0d", w_addr, w_addr_max);

endmodule

/* source/mac_stage.sv */
module mac_stage #(
  parameter int R_DATA_WIDTH = rot_pkg::DEF_R_DATA_WIDTH,
  parameter int ACC_WIDTH    = rot_pkg::DEF_ACC_WIDTH,
  parameter int R_ADDR_WIDTH = 3
)(
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           clken,
  input  logic                           x_valid,
  input  logic signed [R_DATA_WIDTH-1:0] x_data,
  input  rot_pkg::mac_op_e               op,
  input  logic [R_ADDR_WIDTH-1:0]        r_addr_max,
  input  logic signed [R_DATA_WIDTH-1:0] m_data,
  output logic                           r_en,
  output rot_pkg::mac_result_t           result
);

  import rot_pkg::*;

  mac_state_e                     state;
  logic [R_ADDR_WIDTH-1:0]        count;
  mac_op_e                        op_q;
  logic                           first_pixel;
  logic                           last_pixel;
  logic signed [2*R_DATA_WIDTH-1:0] prod;
  logic                           prod_vld;
  logic                           prod_first;
  logic                           prod_last;
  logic signed [ACC_WIDTH-1:0]    acc;
  logic signed [ACC_WIDTH-1:0]    acc_base;
  logic                           sum_vld;

  // every pixel pulls the next weight.
  assign r_en = x_valid;

  assign first_pixel = (state == ST_IDLE);
  assign last_pixel  = (count == r_addr_max);

  // pass control.
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= ST_IDLE;
      count <= '0;
      op_q  <= OP_CLEAR;
    end else if (clken && x_valid) begin
      if (first_pixel) begin
        op_q <= op;
      end
      if (last_pixel) begin
        count <= '0;
        state <= ST_IDLE;
      end else begin
        count <= count + 1'b1;
        state <= ST_RUN;
      end
    end
  end

  // stage 1, multiply.
  always_ff @(posedge clk) begin
    if (rst) begin
      prod_vld   <= 1'b0;
      prod_first <= 1'b0;
      prod_last  <= 1'b0;
    end else if (clken) begin
      prod_vld   <= x_valid;
      prod_first <= x_valid && first_pixel;
      prod_last  <= x_valid && last_pixel;
    end
  end

  always_ff @(posedge clk) begin
    if (clken && x_valid) begin
      prod <= m_data * x_data;
    end
  end

  // a cleared pass starts from zero.
  assign acc_base = (prod_first && (op_q == OP_CLEAR)) ? '0 : acc;

  // stage 2, accumulate.
  always_ff @(posedge clk) begin
    if (rst) begin
      acc     <= '0;
      sum_vld <= 1'b0;
    end else if (clken) begin
      sum_vld <= prod_vld && prod_last;
      if (prod_vld) begin
        acc <= acc_base + ACC_WIDTH'(prod);
      end
    end
  end

  assign result.sum   = acc;
  assign result.valid = sum_vld;

  a_count_in_range: assert property (
    @(posedge clk) disable iff (rst)
    count <= r_addr_max
  ) else $error("mac_stage: pixel count %0d past r_addr_max %0d", count, r_addr_max);

endmodule

/* source/result_clamp.sv */
module result_clamp #(
  parameter  int ACC_WIDTH   = rot_pkg::DEF_ACC_WIDTH,
  localparam int SHIFT_WIDTH = $clog2(ACC_WIDTH)
)(
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   clken,
  input  rot_pkg::mac_result_t   result,
  input  logic [SHIFT_WIDTH-1:0] shift,
  output rot_pkg::out_word_t     out,
  output logic                   out_valid
);

  import rot_pkg::*;

  // signed limits of the output word, at accumulator width.
  localparam logic signed [ACC_WIDTH-1:0] SAT_HI = ACC_WIDTH'((2 ** (OUT_WIDTH - 1)) - 1);
  localparam logic signed [ACC_WIDTH-1:0] SAT_LO = ACC_WIDTH'(-(2 ** (OUT_WIDTH - 1)));

  logic signed [ACC_WIDTH-1:0] shifted;
  out_word_t                   out_next;

  assign shifted = $signed(result.sum) >>> shift;  // keeps the sign.

  always_comb begin
    out_next.sat = 1'b1;
    if (shifted > SAT_HI) begin
      out_next.data = SAT_HI[OUT_WIDTH-1:0];
    end else if (shifted < SAT_LO) begin
      out_next.data = SAT_LO[OUT_WIDTH-1:0];
    end else begin
      out_next.data = shifted[OUT_WIDTH-1:0];
      out_next.sat  = 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
    end else if (clken) begin
      out_valid <= result.valid;  // one enabled cycle.
    end
  end

  // word holds until the next result.
  always_ff @(posedge clk) begin
    if (clken && result.valid) begin
      out <= out_next;
    end
  end

endmodule

/* source/kernel_rotator_top.sv */
module kernel_rotator_top #(
  parameter  int R_DEPTH      = rot_pkg::DEF_R_DEPTH,
  parameter  int R_DATA_WIDTH = rot_pkg::DEF_R_DATA_WIDTH,
  parameter  int W_DATA_WIDTH = rot_pkg::DEF_W_DATA_WIDTH,
  parameter  int ACC_WIDTH    = rot_pkg::DEF_ACC_WIDTH,
  localparam int W_DEPTH      = R_DEPTH * R_DATA_WIDTH / W_DATA_WIDTH,
  localparam int W_ADDR_WIDTH = (W_DEPTH > 1) ? $clog2(W_DEPTH) : 1,
  localparam int R_ADDR_WIDTH = (R_DEPTH > 1) ? $clog2(R_DEPTH) : 1,
  localparam int SHIFT_WIDTH  = $clog2(ACC_WIDTH)
)(
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           clken,
  input  logic [W_DATA_WIDTH-1:0]        beat,
  input  logic                           beat_valid,
  input  logic [W_ADDR_WIDTH-1:0]        w_addr_max,
  input  logic [R_ADDR_WIDTH-1:0]        r_addr_max,
  input  logic signed [R_DATA_WIDTH-1:0] x_data,
  input  logic                           x_valid,
  input  rot_pkg::mac_op_e               op,
  input  logic [SHIFT_WIDTH-1:0]         shift,
  output logic                           loaded,
  output rot_pkg::out_word_t             out,
  output logic                           out_valid
);

  import rot_pkg::*;

  logic                    w_en;
  logic [W_ADDR_WIDTH-1:0] w_addr;
  logic                    r_en;
  logic [R_DATA_WIDTH-1:0] m_data;
  mac_result_t             mac_result;

  weight_loader #(
    .W_ADDR_WIDTH (W_ADDR_WIDTH)
  ) loader_i (
    .clk        (clk),
    .rst        (rst),
    .clken      (clken),
    .beat_valid (beat_valid),
    .w_addr_max (w_addr_max),
    .w_en       (w_en),
    .w_addr     (w_addr),
    .loaded     (loaded)
  );

  // loader owns the write address.
  cyclic_shift_reg #(
    .R_DEPTH         (R_DEPTH),
    .R_DATA_WIDTH    (R_DATA_WIDTH),
    .W_DATA_WIDTH    (W_DATA_WIDTH),
    .OVERRIDE_W_ADDR (1'b1)
  ) buffer_i (
    .clk        (clk),
    .clken      (clken),
    .rst        (rst),
    .w_en       (w_en),
    .r_en       (r_en),
    .s_data     (beat),
    .m_data     (m_data),
    .r_addr_max (r_addr_max),
    .w_addr_max (w_addr_max),
    .w_addr_in  (w_addr)
  );

  mac_stage #(
    .R_DATA_WIDTH (R_DATA_WIDTH),
    .ACC_WIDTH    (ACC_WIDTH),
    .R_ADDR_WIDTH (R_ADDR_WIDTH)
  ) mac_i (
    .clk        (clk),
    .rst        (rst),
    .clken      (clken),
    .x_valid    (x_valid),
    .x_data     (x_data),
    .op         (op),
    .r_addr_max (r_addr_max),
    .m_data     (m_data),
    .r_en       (r_en),
    .result     (mac_result)
  );

  result_clamp #(
    .ACC_WIDTH (ACC_WIDTH)
  ) clamp_i (
    .clk       (clk),
    .rst       (rst),
    .clken     (clken),
    .result    (mac_result),
    .shift     (shift),
    .out       (out),
    .out_valid (out_valid)
  );

endmodule

/* sim/kernel_rotator_tb.sv */
module kernel_rotator_tb;
  timeunit 1ns;
  timeprecision 1ps;

  import rot_pkg::*;

  localparam int R_DEPTH      = DEF_R_DEPTH;
  localparam int DW           = DEF_R_DATA_WIDTH;
  localparam int RATIO        = DEF_W_DATA_WIDTH / DEF_R_DATA_WIDTH;
  localparam int BEATS        = R_DEPTH / RATIO;
  localparam int W_ADDR_WIDTH = (BEATS > 1) ? $clog2(BEATS) : 1;
  localparam int R_ADDR_WIDTH = (R_DEPTH > 1) ? $clog2(R_DEPTH) : 1;
  localparam int SHIFT_WIDTH  = $clog2(DEF_ACC_WIDTH);
  localparam int WAIT_LIMIT   = 200;

  logic                        clk;
  logic                        rst;
  logic                        clken;
  logic [DEF_W_DATA_WIDTH-1:0] beat;
  logic                        beat_valid;
  logic [W_ADDR_WIDTH-1:0]     w_addr_max;
  logic [R_ADDR_WIDTH-1:0]     r_addr_max;
  logic signed [DW-1:0]        x_data;
  logic                        x_valid;
  mac_op_e                     op;
  logic [SHIFT_WIDTH-1:0]      shift;
  logic                        loaded;
  out_word_t                   out;
  logic                        out_valid;

  // reference model state.
  logic signed [DW-1:0] shadow [R_DEPTH];
  longint               model_acc;
  int                   model_count;
  logic                 px_last;      // marks the final pixel of a pass.
  out_word_t            px_exp;
  logic                 beat_last;
  logic [2:0]           last_pipe;
  out_word_t            word_pipe [3];
  logic                 exp_loaded;
  logic [31:0]          rng;
  int                   errors;
  int                   results_seen;
  int                   results_issued;
  int                   tests_run;

  kernel_rotator_top kernel_rotator_top_i (
    .clk        (clk),
    .rst        (rst),
    .clken      (clken),
    .beat       (beat),
    .beat_valid (beat_valid),
    .w_addr_max (w_addr_max),
    .r_addr_max (r_addr_max),
    .x_data     (x_data),
    .x_valid    (x_valid),
    .op         (op),
    .shift      (shift),
    .loaded     (loaded),
    .out        (out),
    .out_valid  (out_valid)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // expected timing, advanced on enabled edges only.
  always @(posedge clk) begin
    if (rst) begin
      last_pipe    <= '0;
      exp_loaded   <= 1'b0;
      results_seen <= 0;
    end else if (clken) begin
      last_pipe    <= {last_pipe[1:0], x_valid && px_last};
      word_pipe[0] <= px_exp;
      word_pipe[1] <= word_pipe[0];
      word_pipe[2] <= word_pipe[1];
      if (beat_valid) begin
        exp_loaded <= beat_last;
      end
      if (out_valid) begin
        results_seen <= results_seen + 1;
      end
    end
  end

  a_valid_timing: assert property (@(posedge clk) disable iff (rst) out_valid == last_pipe[2])
    else begin
      errors++;
      $display("ERROR at %0t: out_valid %0b, expected %0b", $time,
               $sampled(out_valid), $sampled(last_pipe[2]));
    end

  a_out_word: assert property (@(posedge clk) disable iff (rst) out_valid |-> out == word_pipe[2])
    else begin
      errors++;
      $display("ERROR at %0t: out %0d sat %0b, expected %0d sat %0b", $time,
               $sampled(out.data), $sampled(out.sat),
               $sampled(word_pipe[2].data), $sampled(word_pipe[2].sat));
    end

  a_loaded: assert property (@(posedge clk) disable iff (rst) loaded == exp_loaded)
    else begin
      errors++;
      $display("ERROR at %0t: loaded %0b, expected %0b", $time,
               $sampled(loaded), $sampled(exp_loaded));
    end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] v;
    v = s;
    v ^= v << 13;
    v ^= v >> 17;
    v ^= v << 5;
    return v;
  endfunction

  // small signed values keep most sums inside the output range.
  function automatic logic signed [DW-1:0] rand_word();
    rng = xorshift(rng);
    return {{(DW-10){rng[9]}}, rng[9:0]};
  endfunction

  function automatic out_word_t clamp_ref(input longint sum, input int sh);
    longint    v;
    out_word_t w;
    v = sum >>> sh;
    w.sat = 1'b1;
    if (v > 32767) begin
      w.data = 16'sh7fff;
    end else if (v < -32768) begin
      w.data = 16'sh8000;
    end else begin
      w.data = v[15:0];
      w.sat  = 1'b0;
    end
    return w;
  endfunction

  task automatic fail_timeout(input string what);
    $display("timeout while waiting for %s", what);
    $display("Finished with errors");
    $finish;
  endtask

  task automatic load_kernel(input bit fixed, input logic signed [DW-1:0] fixed_val);
    logic signed [DW-1:0] w;
    for (int b = 0; b < BEATS; b++) begin
      for (int k = 0; k < RATIO; k++) begin
        w = fixed ? fixed_val : rand_word();
        shadow[b*RATIO+k] = w;  // placement rule.
        beat[k*DW +: DW]  = w;
      end
      beat_valid = 1'b1;
      beat_last  = (b == BEATS - 1);
      @(negedge clk);
    end
    beat_valid = 1'b0;
    beat_last  = 1'b0;
  endtask

  task automatic send_pixel(input logic signed [DW-1:0] x, input mac_op_e pass_op,
                            input int stall);
    logic signed [DW-1:0] w;
    w = shadow[0];
    for (int p = 0; p < int'(r_addr_max); p++) begin
      shadow[p] = shadow[p+1];
    end
    shadow[r_addr_max] = w;
    if (model_count == 0 && pass_op == OP_CLEAR) begin
      model_acc = 0;
    end
    model_acc += longint'(w) * longint'(x);
    px_last = (model_count == int'(r_addr_max));
    if (px_last) begin
      px_exp      = clamp_ref(model_acc, int'(shift));
      model_count = 0;
      results_issued++;
    end else begin
      model_count++;
    end
    x_valid = 1'b1;
    x_data  = x;
    op      = pass_op;
    if (stall > 0) begin
      clken = 1'b0;  // pixel held while frozen.
      repeat (stall) @(negedge clk);
      clken = 1'b1;
    end
    @(negedge clk);
    x_valid = 1'b0;
    px_last = 1'b0;
  endtask

  task automatic run_pass(input mac_op_e pass_op, input bit fixed,
                          input logic signed [DW-1:0] fixed_val, input int stall_at);
    for (int i = 0; i <= int'(r_addr_max); i++) begin
      send_pixel(fixed ? fixed_val : rand_word(), pass_op, (i == stall_at) ? 3 : 0);
    end
  endtask

  task automatic wait_results();
    int n;
    n = 0;
    while (results_seen < results_issued) begin
      if (n == WAIT_LIMIT) begin
        fail_timeout("out_valid");
      end
      @(negedge clk);
      n++;
    end
  endtask

  task automatic wait_loaded();
    int n;
    n = 0;
    while (!loaded) begin
      if (n == WAIT_LIMIT) begin
        fail_timeout("loaded");
      end
      @(negedge clk);
      n++;
    end
  endtask

  task automatic report(input string name, input int errs_before);
    tests_run++;
    $display("test %0d %s: %s", tests_run, name, (errors == errs_before) ? "ok" : "failed");
  endtask

  initial begin
    int e;
    rst            = 1'b1;
    clken          = 1'b1;
    beat           = '0;
    beat_valid     = 1'b0;
    beat_last      = 1'b0;
    w_addr_max     = W_ADDR_WIDTH'(BEATS - 1);
    r_addr_max     = R_ADDR_WIDTH'(R_DEPTH - 1);
    x_data         = '0;
    x_valid        = 1'b0;
    op             = OP_CLEAR;
    shift          = SHIFT_WIDTH'(8);
    px_last        = 1'b0;
    px_exp         = '0;
    rng            = 32'h126b3935;
    model_acc      = 0;
    model_count    = 0;
    errors         = 0;
    results_issued = 0;
    tests_run      = 0;
    for (int i = 0; i < R_DEPTH; i++) begin
      shadow[i] = '0;
    end
    repeat (4) @(negedge clk);
    rst = 1'b0;

    e = errors;
    load_kernel(1'b0, '0);
    wait_loaded();
    run_pass(OP_CLEAR, 1'b0, '0, -1);
    wait_results();
    report("full load and cleared pass", e);

    e = errors;
    run_pass(OP_CLEAR, 1'b0, '0, -1);  // kernel back at position 0.
    wait_results();
    report("rotation restores kernel", e);

    e = errors;
    r_addr_max = R_ADDR_WIDTH'(3);
    repeat (3) run_pass(OP_CLEAR, 1'b0, '0, -1);
    wait_results();
    report("short kernel", e);

    e = errors;
    r_addr_max = R_ADDR_WIDTH'(R_DEPTH - 1);
    run_pass(OP_CLEAR, 1'b0, '0, -1);
    run_pass(OP_ACCUM, 1'b0, '0, -1);  // overlaps the previous drain.
    wait_results();
    report("accumulate over two passes", e);

    e = errors;
    load_kernel(1'b1, 16'sh7000);
    wait_loaded();
    shift = '0;
    run_pass(OP_CLEAR, 1'b1, 16'sh7000, -1);
    wait_results();
    run_pass(OP_CLEAR, 1'b1, -16'sh7000, -1);
    wait_results();
    shift = SHIFT_WIDTH'(20);
    run_pass(OP_CLEAR, 1'b1, 16'sh7000, -1);
    wait_results();
    report("shift and saturation", e);

    e = errors;
    load_kernel(1'b0, '0);
    wait_loaded();
    shift = SHIFT_WIDTH'(8);
    run_pass(OP_CLEAR, 1'b0, '0, 2);
    clken = 1'b0;  // freeze the drain too.
    repeat (5) @(negedge clk);
    clken = 1'b1;
    wait_results();
    report("clock enable stall", e);

    repeat (4) @(negedge clk);
    $display("tests %0d, results %0d, errors %0d", tests_run, results_seen, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

/* sources.f */
source/rot_pkg.sv
source/weight_loader.sv
source/cyclic_shift_reg.sv
source/mac_stage.sv
source/result_clamp.sv
source/kernel_rotator_top.sv
sim/kernel_rotator_tb.sv

/* Makefile */
# Verilator simulation of the kernel rotator testbench.

VERILATOR ?= verilator
TOP       ?= kernel_rotator_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Finished with no errors

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		-Mdir $(BUILD_DIR) -o V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	if echo "$$out" | grep -qx "$(PASS_MSG)"; then \
		exit 0; \
	else \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR)
